// ==== test/vlsu_vectors.txt ====
# op mode width base stride store_data expected_load, all fields hex
# op 0 load 1 store, mode 0 unit-stride 1 strided, width 0 EW8 1 EW16 2 EW32
0 0 2 00000010 00000000 0000000000000000 b2b3b0b1b6b7b4b5
0 1 0 00000020 00000003 0000000000000000 90978a898c838685
1 1 1 00000040 00000006 70815e6f3c4d1a2b 0000000000000000
0 0 2 00000040 00000000 0000000000000000 3c4de0e1e6e71a2b
0 0 2 0000004c 00000000 0000000000000000 7081f4f5eaeb5e6f
1 0 2 00000080 00000000 0123456789abcdef 0000000000000000
0 1 2 00000080 00000004 0000000000000000 0123456789abcdef
0 1 1 00000060 0000000a 0000000000000000 dadbd0d1cecfc4c5
1 1 0 00000090 00000005 8877665544332211 0000000000000000
0 1 0 00000090 00000005 0000000000000000 8877665544332211
1 1 2 000000c0 00000008 cafef00ddeadbeef 0000000000000000
0 0 0 000000c0 00000000 0000000000000000 62636061deadbeef

// ==== list.f ====
common/vlsu_geom_pkg.sv
common/vlsu_bus_pkg.sv
vlsu/vlsu_cmd_capture.sv
vlsu/vlsu_sequencer.sv
vlsu/vlsu_wb_master.sv
rtl/vlsu_top.sv
test/tb_vlsu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the obj_dir build folder"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module tb_vlsu
	@out="$$(./obj_dir/Vtb_vlsu)"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// ==== test/tb_vlsu.sv ====
`timescale 1ns/1ps

module tb_vlsu
    import vlsu_geom_pkg::*;
    import vlsu_bus_pkg::*;
();

    localparam int MAX_VECTORS = 64;
    localparam int LOG_DEPTH   = 512;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        start_i;
    logic        is_store_i;
    addr_mode_e  addr_mode_i;
    elem_width_e elem_width_i;
    addr_t       base_address_i;
    addr_t       stride_i;
    vreg_t       store_data_i;
    logic        busy_o;
    logic        done_o;
    vreg_t       load_data_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    addr_t       wb_adr_o;
    sel_t        wb_sel_o;
    word_t       wb_dat_o;
    logic        wb_ack_i = 1'b0;
    word_t       wb_dat_i = '0;

    // Vectors from the data file
    logic        vec_op     [0:MAX_VECTORS-1];
    logic        vec_mode   [0:MAX_VECTORS-1];
    logic [1:0]  vec_width  [0:MAX_VECTORS-1];
    addr_t       vec_base   [0:MAX_VECTORS-1];
    addr_t       vec_stride [0:MAX_VECTORS-1];
    vreg_t       vec_store  [0:MAX_VECTORS-1];
    vreg_t       vec_expect [0:MAX_VECTORS-1];
    int          n_vec;

    // Slave memory and bus log
    logic [7:0]  mem [0:255];
    logic        slave_busy;
    int          wait_left;
    int          seed = 99860;
    addr_t       adr_log [0:LOG_DEPTH-1];
    sel_t        sel_log [0:LOG_DEPTH-1];
    logic        we_log  [0:LOG_DEPTH-1];
    int          ack_total = 0;
    int          done_total = 0;

    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          cycle_limit;

    vlsu_top dut_i (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone slave with random wait states
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t read_word(input addr_t adr);
        logic [7:0] a;
        a = {adr[7:2], 2'b00};
        return {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack_i   <= 1'b0;
            wb_dat_i   <= '0;
            slave_busy <= 1'b0;
            wait_left  <= 0;
            // Every byte holds its own address XOR A5
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 8'(i) ^ 8'hA5;
            end
        end
        else begin
            wb_ack_i <= 1'b0;
            if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
                if (!slave_busy) begin
                    slave_busy <= 1'b1;
                    wait_left  <= {$random(seed)} % 4;
                end
                else if (wait_left > 0) begin
                    wait_left <= wait_left - 1;
                end
                else begin
                    slave_busy <= 1'b0;
                    wb_ack_i   <= 1'b1;
                    wb_dat_i   <= read_word(wb_adr_o);
                    if (wb_we_o) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wb_sel_o[b]) begin
                                mem[{wb_adr_o[7:2], 2'(b)}] <= wb_dat_o[8*b +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

    // Access monitor logs every acknowledged cycle
    always @(posedge clk) begin
        if (wb_cyc_o && wb_stb_o && wb_ack_i && ack_total < LOG_DEPTH) begin
            adr_log[ack_total] <= wb_adr_o;
            sel_log[ack_total] <= wb_sel_o;
            we_log[ack_total]  <= wb_we_o;
            ack_total          <= ack_total + 1;
        end
        if (done_o) begin
            done_total <= done_total + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, done_o never came", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    function automatic sel_t expected_sel(input logic mode, input logic [1:0] width,
                                          input addr_t adr);
        if (mode == 1'b0 || width == 2'd2) begin
            return 4'b1111;
        end
        if (width == 2'd1) begin
            return adr[1] ? 4'b1100 : 4'b0011;
        end
        return sel_t'(4'b0001 << adr[1:0]);
    endfunction

    // Bus accesses that one command makes
    function automatic int access_count(input logic mode, input logic [1:0] width);
        if (mode == 1'b0 || width == 2'd2) begin
            return 2;
        end
        if (width == 2'd1) begin
            return 4;
        end
        return 8;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [63:0] f_op;
        logic [63:0] f_mode;
        logic [63:0] f_width;
        logic [63:0] f_base;
        logic [63:0] f_stride;
        logic [63:0] f_store;
        logic [63:0] f_expect;
        n_vec = 0;
        fd = $fopen("test/vlsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/vlsu_vectors.txt");
        end
        else begin
            while (!$feof(fd) && n_vec < MAX_VECTORS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_mode, f_width,
                                   f_base, f_stride, f_store, f_expect);
                    if (code == 7) begin
                        vec_op[n_vec]     = f_op[0];
                        vec_mode[n_vec]   = f_mode[0];
                        vec_width[n_vec]  = f_width[1:0];
                        vec_base[n_vec]   = addr_t'(f_base);
                        vec_stride[n_vec] = addr_t'(f_stride);
                        vec_store[n_vec]  = f_store;
                        vec_expect[n_vec] = f_expect;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Odd commands keep start_i high until done_o to probe the busy guard
    task automatic run_command(input int t);
        int    ack_base;
        int    done_base;
        int    errs_before;
        int    n_acc;
        int    exp_count;
        logic  hold;
        addr_t step;
        addr_t exp_adr;
        vreg_t held_load;
        ack_base    = ack_total;
        done_base   = done_total;
        errs_before = error_count;
        held_load   = load_data_o;
        hold        = (t % 2 == 1);
        step        = vec_mode[t] ? vec_stride[t] : addr_t'(WORD_BYTES);
        exp_count   = access_count(vec_mode[t], vec_width[t]);

        @(posedge clk);
        start_i        <= 1'b1;
        is_store_i     <= vec_op[t];
        addr_mode_i    <= addr_mode_e'(vec_mode[t]);
        elem_width_i   <= elem_width_e'(vec_width[t]);
        base_address_i <= vec_base[t];
        stride_i       <= vec_stride[t];
        store_data_i   <= vec_store[t];
        if (!hold) begin
            @(posedge clk);
            start_i <= 1'b0;
        end
        @(negedge clk);
        while (!done_o) begin
            @(negedge clk);
        end

        if (vec_op[t]) begin
            check_value("load_data_o", held_load, load_data_o);
        end
        else begin
            check_value("load_data_o", vec_expect[t], load_data_o);
        end
        if (hold) begin
            @(posedge clk);
            start_i <= 1'b0;
        end
        repeat (3) @(negedge clk);

        n_acc = ack_total - ack_base;
        check_value("access count", 64'(exp_count), 64'(n_acc));
        check_value("done_o pulse count", 64'd1, 64'(done_total - done_base));
        check_value("busy_o", 64'd0, 64'(busy_o));
        for (int k = 0; k < n_acc && k < exp_count; k++) begin
            exp_adr = vec_base[t] + addr_t'(k) * step;
            check_value("wb_adr_o", 64'(exp_adr), 64'(adr_log[ack_base + k]));
            check_value("wb_sel_o", 64'(expected_sel(vec_mode[t], vec_width[t], exp_adr)),
                        64'(sel_log[ack_base + k]));
            check_value("wb_we_o", 64'(vec_op[t]), 64'(we_log[ack_base + k]));
        end

        if (error_count == errs_before) begin
            pass_count++;
        end
        else begin
            fail_count++;
        end
        $display("test %0d: %s %s ew%0d base %h, %0d accesses%s: %s", t + 1,
                 vec_op[t] ? "store" : "load", vec_mode[t] ? "strided" : "unit-stride",
                 8 << vec_width[t], vec_base[t], n_acc, hold ? ", start held" : "",
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        load_vectors();
        cycle_limit    = n_vec * 8 * 6 + 100;
        reset_n        = 1'b0;
        start_i        = 1'b0;
        is_store_i     = 1'b0;
        addr_mode_i    = UNIT_STRIDED;
        elem_width_i   = EW8;
        base_address_i = '0;
        stride_i       = '0;
        store_data_i   = '0;

        if (n_vec == 0) begin
            $display("No vectors read, nothing to run");
            $display("Test failed");
        end
        else begin
            repeat (5) @(posedge clk);
            reset_n <= 1'b1;
            @(negedge clk);

            // Idle state straight out of reset
            check_value("busy_o", 64'd0, 64'(busy_o));
            check_value("done_o", 64'd0, 64'(done_o));
            check_value("wb_cyc_o", 64'd0, 64'(wb_cyc_o));
            check_value("wb_stb_o", 64'd0, 64'(wb_stb_o));
            check_value("wb_we_o", 64'd0, 64'(wb_we_o));
            check_value("load_data_o", 64'd0, load_data_o);
            if (error_count == 0) begin
                pass_count++;
            end
            else begin
                fail_count++;
            end
            $display("test 0: reset state: %s", (error_count == 0) ? "ok" : "mismatch");

            for (int t = 0; t < n_vec; t++) begin
                run_command(t);
            end

            $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
                     pass_count + fail_count, pass_count, fail_count, error_count);
            if (error_count == 0) begin
                $display("Test passed");
            end
            else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

// ==== rtl/vlsu_top.sv ====
`timescale 1ns/1ps

module vlsu_top
    import vlsu_geom_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Core side
    input  logic        start_i,
    input  logic        is_store_i,
    input  addr_mode_e  addr_mode_i,
    input  elem_width_e elem_width_i,
    input  addr_t       base_address_i,
    input  addr_t       stride_i,
    input  vreg_t       store_data_i,
    output logic        busy_o,
    output logic        done_o,
    output vreg_t       load_data_o,

    // Wishbone classic master
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output addr_t       wb_adr_o,
    output sel_t        wb_sel_o,
    output word_t       wb_dat_o,
    input  logic        wb_ack_i,
    input  word_t       wb_dat_i
);

    // Latched command
    logic        cmd_valid;
    logic        cmd_is_store;
    addr_mode_e  cmd_addr_mode;
    elem_width_e cmd_elem_width;
    addr_t       cmd_base;
    addr_t       cmd_stride;
    vreg_t       cmd_store_data;
    elem_idx_t   cmd_elem_count;

    // Sequencer to bus master handshake
    logic        acc_req;
    logic        acc_ack;
    addr_t       acc_addr;
    elem_idx_t   acc_idx;
    logic        busy;

    assign busy_o = busy;

    vlsu_cmd_capture capture_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .busy_i         (busy),
        .is_store_i     (is_store_i),
        .addr_mode_i    (addr_mode_i),
        .elem_width_i   (elem_width_i),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .store_data_i   (store_data_i),
        .cmd_valid_o    (cmd_valid),
        .is_store_o     (cmd_is_store),
        .addr_mode_o    (cmd_addr_mode),
        .elem_width_o   (cmd_elem_width),
        .base_o         (cmd_base),
        .stride_o       (cmd_stride),
        .store_data_o   (cmd_store_data),
        .elem_count_o   (cmd_elem_count)
    );

    vlsu_sequencer sequencer_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_valid_i  (cmd_valid),
        .addr_mode_i  (cmd_addr_mode),
        .base_i       (cmd_base),
        .stride_i     (cmd_stride),
        .elem_count_i (cmd_elem_count),
        .acc_ack_i    (acc_ack),
        .acc_req_o    (acc_req),
        .acc_addr_o   (acc_addr),
        .acc_idx_o    (acc_idx),
        .busy_o       (busy),
        .done_o       (done_o)
    );

    vlsu_wb_master wb_master_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_valid_i  (cmd_valid),
        .acc_req_i    (acc_req),
        .acc_addr_i   (acc_addr),
        .acc_idx_i    (acc_idx),
        .is_store_i   (cmd_is_store),
        .addr_mode_i  (cmd_addr_mode),
        .elem_width_i (cmd_elem_width),
        .store_data_i (cmd_store_data),
        .wb_ack_i     (wb_ack_i),
        .wb_dat_i     (wb_dat_i),
        .acc_ack_o    (acc_ack),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_sel_o     (wb_sel_o),
        .wb_dat_o     (wb_dat_o),
        .load_data_o  (load_data_o)
    );

endmodule

// ==== vlsu/vlsu_wb_master.sv ====
`timescale 1ns/1ps

module vlsu_wb_master
    import vlsu_geom_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Command and access request
    input  logic        cmd_valid_i,
    input  logic        acc_req_i,
    input  addr_t       acc_addr_i,
    input  elem_idx_t   acc_idx_i,
    input  logic        is_store_i,
    input  addr_mode_e  addr_mode_i,
    input  elem_width_e elem_width_i,
    input  vreg_t       store_data_i,

    // Wishbone slave response
    input  logic        wb_ack_i,
    input  word_t       wb_dat_i,

    output logic        acc_ack_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output addr_t       wb_adr_o,
    output sel_t        wb_sel_o,
    output word_t       wb_dat_o,
    output vreg_t       load_data_o
);

    elem_width_e           place_width;
    logic [$clog2(VLEN)-1:0] bit_ofs;
    vreg_t                 elem_mask;
    word_t                 store_elem;
    word_t                 lane_data;
    vreg_t                 load_q;

    ////////////////////////////////////////////////////////////////////////////
    // Element placement inside the register
    ////////////////////////////////////////////////////////////////////////////

    // Unit-stride moves whole words, so it is placed like an EW32 element
    assign place_width = (addr_mode_i == UNIT_STRIDED) ? EW32 : elem_width_i;

    always_comb begin
        unique case (place_width)
            EW8: begin
                bit_ofs   = {acc_idx_i[2:0], 3'b000};
                elem_mask = vreg_t'(8'hFF);
            end
            EW16: begin
                bit_ofs   = {acc_idx_i[1:0], 4'b0000};
                elem_mask = vreg_t'(16'hFFFF);
            end
            default: begin
                bit_ofs   = {acc_idx_i[0], 5'b00000};
                elem_mask = vreg_t'(32'hFFFF_FFFF);
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////////////////////////////////////////

    assign store_elem = word_t'(store_data_i >> bit_ofs);

    // Element replicated on every lane, select picks the addressed one
    always_comb begin
        unique case (place_width)
            EW8: begin
                wb_dat_o = {4{store_elem[7:0]}};
                wb_sel_o = sel_t'(4'b0001) << acc_addr_i[1:0];
            end
            EW16: begin
                wb_dat_o = {2{store_elem[15:0]}};
                wb_sel_o = acc_addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wb_dat_o = store_elem;
                wb_sel_o = 4'b1111;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus cycle
    ////////////////////////////////////////////////////////////////////////////

    // One access per request, cyc and stb share the request register
    assign wb_cyc_o  = acc_req_i;
    assign wb_stb_o  = acc_req_i;
    assign wb_we_o   = acc_req_i && is_store_i;
    assign wb_adr_o  = acc_addr_i;
    assign acc_ack_o = wb_ack_i && wb_stb_o;

    ////////////////////////////////////////////////////////////////////////////
    // Load assembly
    ////////////////////////////////////////////////////////////////////////////

    // Addressed lane moved down to bit 0
    assign lane_data = wb_dat_i >> {acc_addr_i[1:0], 3'b000};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            load_q <= '0;
        end
        else if (cmd_valid_i && !is_store_i) begin
            load_q <= '0;
        end
        else if (acc_ack_o && !is_store_i) begin
            load_q <= (load_q & ~(elem_mask << bit_ofs))
                    | ((vreg_t'(lane_data) & elem_mask) << bit_ofs);
        end
    end

    assign load_data_o = load_q;

    // Classic cycle: nothing moves until the slave answers
    bus_stable_a : assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && wb_cyc_o
            && $stable(wb_adr_o) && $stable(wb_sel_o)
            && $stable(wb_we_o) && $stable(wb_dat_o));

endmodule

// ==== vlsu/vlsu_sequencer.sv ====
`timescale 1ns/1ps

module vlsu_sequencer
    import vlsu_geom_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  logic       cmd_valid_i,
    input  addr_mode_e addr_mode_i,
    input  addr_t      base_i,
    input  addr_t      stride_i,
    input  elem_idx_t  elem_count_i,
    input  logic       acc_ack_i,

    output logic       acc_req_o,
    output addr_t      acc_addr_o,
    output elem_idx_t  acc_idx_o,
    output logic       busy_o,
    output logic       done_o
);

    seq_state_e state_q;
    seq_state_e state_d;
    addr_t      offset_q;
    addr_t      step;
    elem_idx_t  idx_q;
    elem_idx_t  idx_next;
    logic       req_q;
    logic       last_ack;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    assign idx_next = idx_q + elem_idx_t'(1);
    assign last_ack = acc_ack_i && (idx_next == elem_count_i);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            SEQ_IDLE: begin
                if (cmd_valid_i) begin
                    state_d = SEQ_ACCESS;
                end
            end
            SEQ_ACCESS: begin
                if (last_ack) begin
                    state_d = SEQ_DONE;
                end
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= SEQ_IDLE;
        end
        else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Element walk and address
    ////////////////////////////////////////////////////////////////////////////

    assign step = (addr_mode_i == UNIT_STRIDED) ? addr_t'(WORD_BYTES) : stride_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_q <= '0;
            idx_q    <= '0;
            req_q    <= 1'b0;
        end
        else if (state_q == SEQ_IDLE) begin
            offset_q <= '0;
            idx_q    <= '0;
            req_q    <= cmd_valid_i;
        end
        else if (state_q == SEQ_ACCESS) begin
            if (acc_ack_i) begin
                // Drop the request for one cycle between accesses
                req_q    <= 1'b0;
                offset_q <= offset_q + step;
                idx_q    <= idx_next;
            end
            else begin
                req_q <= 1'b1;
            end
        end
    end

    assign acc_req_o  = req_q;
    assign acc_addr_o = base_i + offset_q;
    assign acc_idx_o  = idx_q;

    // Busy already in the cycle the command reaches us
    assign busy_o = cmd_valid_i || (state_q != SEQ_IDLE);
    assign done_o = (state_q == SEQ_DONE);

    req_held_a : assert property (@(posedge clk) disable iff (!reset_n)
        acc_req_o && !acc_ack_i |=> acc_req_o && $stable(acc_idx_o) && $stable(acc_addr_o));

    idx_in_range_a : assert property (@(posedge clk) disable iff (!reset_n)
        acc_req_o |-> acc_idx_o < elem_count_i);

endmodule

// ==== vlsu/vlsu_cmd_capture.sv ====
`timescale 1ns/1ps

module vlsu_cmd_capture
    import vlsu_geom_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    input  logic        start_i,
    input  logic        busy_i,
    input  logic        is_store_i,
    input  addr_mode_e  addr_mode_i,
    input  elem_width_e elem_width_i,
    input  addr_t       base_address_i,
    input  addr_t       stride_i,
    input  vreg_t       store_data_i,

    output logic        cmd_valid_o,
    output logic        is_store_o,
    output addr_mode_e  addr_mode_o,
    output elem_width_e elem_width_o,
    output addr_t       base_o,
    output addr_t       stride_o,
    output vreg_t       store_data_o,
    output elem_idx_t   elem_count_o
);

    logic      accept;
    elem_idx_t elem_count;

    // A start while a command is in flight is dropped
    assign accept = start_i && !busy_i;

    // Accesses per register
    always_comb begin
        if (addr_mode_i == UNIT_STRIDED) begin
            // Whole words, element width does not matter
            elem_count = elem_idx_t'(VLENB / WORD_BYTES);
        end
        else begin
            elem_count = elem_idx_t'(VLENB >> elem_width_i);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_valid_o <= 1'b0;
        end
        else begin
            cmd_valid_o <= accept;
        end
    end

    // Command fields
    always_ff @(posedge clk) begin
        if (accept) begin
            is_store_o   <= is_store_i;
            addr_mode_o  <= addr_mode_i;
            elem_width_o <= elem_width_i;
            base_o       <= base_address_i;
            stride_o     <= stride_i;
            store_data_o <= store_data_i;
            elem_count_o <= elem_count;
        end
    end

    // Unit-stride runs only whole aligned words on the bus
    unit_base_aligned_a : assert property (@(posedge clk) disable iff (!reset_n)
        accept && addr_mode_i == UNIT_STRIDED |-> base_address_i[1:0] == 2'b00);

endmodule

// ==== common/vlsu_bus_pkg.sv ====
package vlsu_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone bus geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_BITS  = 32;
    localparam int WORD_BITS  = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;

    // Byte address on the bus
    typedef logic [ADDR_BITS-1:0] addr_t;

    // One bus data word
    typedef logic [WORD_BITS-1:0] word_t;

    // One select bit per byte lane
    typedef logic [WORD_BYTES-1:0] sel_t;

    // Access sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_ACCESS = 2'd1,
        SEQ_DONE   = 2'd2
    } seq_state_e;

endpackage

// ==== common/vlsu_geom_pkg.sv ====
package vlsu_geom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector register geometry
    ////////////////////////////////////////////////////////////////////////////

    // Register width in bits and in bytes
    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    // Holds any element index or count from 0 up to VLENB
    localparam int ELEM_IDX_BITS = 4;

    // One whole vector register
    typedef logic [VLEN-1:0] vreg_t;

    // Element index inside a register, or the element count of a command
    typedef logic [ELEM_IDX_BITS-1:0] elem_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // Command fields
    ////////////////////////////////////////////////////////////////////////////

    // Encoding is log2 of the element size in bytes,
    // so VLENB >> width gives elements per register
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    // Unit-stride walks consecutive words, strided takes one element per access
    typedef enum logic {
        UNIT_STRIDED = 1'b0,
        STRIDED      = 1'b1
    } addr_mode_e;

endpackage
